/* hdl/frontend_pkg.sv */
////////////////////////////////////////////////////////////
// front end shared definitions
// alu and operand select encodings, rv32 instruction
// formats with a union over one word, and the packets
// that travel between fetch, decode and dispatch
////////////////////////////////////////////////////////////

package frontend_pkg;

	// datapath width and the hardwired zero register
	localparam int xlen = 32;
	localparam logic [4:0] zero_reg = 5'd0;

	// major opcodes, low seven bits of every instruction
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;

	////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra,
		alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} alu_func_t;

	typedef enum logic [1:0] {
		opa_rs1, opa_pc, opa_zero
	} opa_sel_t;

	typedef enum logic [2:0] {
		opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm
	} opb_sel_t;

	////////////////////////////////////////////////////////////
	// instruction formats, msb first
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	// store immediate split around rs fields
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one word, read through whichever view fits
	typedef union packed {
		logic [31:0] raw;
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

	////////////////////////////////////////////////////////////
	// stage packets
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_t inst;
	} fetch_pkt_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_t inst;
		opa_sel_t opa_sel;
		opb_sel_t opb_sel;
		alu_func_t alu_func;
		logic [4:0] dest_idx;
		logic [4:0] rs1_idx;
		logic rs1_used;
		logic [4:0] rs2_idx;
		logic rs2_used;
		logic rd_mem;
		logic wr_mem;
		logic cond_branch;
		logic uncond_branch;
		logic csr_op;
		logic halt;
		logic illegal;
	} decoded_pkt_t;

endpackage

/* hdl/stage_if.sv */
////////////////////////////////////////////////////////////
// stage handshake
// valid/ready link carrying one packet of any type
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface stage_if #(
	parameter type pkt_t = logic
) ();

	// transfer on a rising edge with valid and ready high
	logic valid;
	logic ready;
	pkt_t pkt;

	// upstream side, holds valid and pkt until taken
	modport producer (output valid, output pkt, input ready);

	// downstream side
	modport consumer (input valid, input pkt, output ready);

endinterface

/* hdl/fetch_stage.sv */
////////////////////////////////////////////////////////////
// fetch stage
// program counter over a 64-bit instruction memory, picks
// the 32-bit half by pc bit 2, redirects on squash and
// parks after a halt until the next squash
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_stage import frontend_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input logic clock,
	input logic reset,
	input logic squash,
	input logic [xlen-1:0] squash_pc,
	input logic halt_accepted,
	output logic [xlen-1:0] imem_addr,
	input logic [63:0] imem_data,
	stage_if.producer out
);

	logic [xlen-1:0] pc;
	logic halted;
	logic fire;
	fetch_pkt_t fetch_pkt;

	// memory is doubleword addressed
	assign imem_addr = {pc[xlen-1:3], 3'b000};

	// imem answers in the same cycle, so valid is just not halted
	always_comb begin
		fetch_pkt.pc = pc;
		fetch_pkt.inst.raw = pc[2] ? imem_data[63:32] : imem_data[31:0];
	end

	assign out.valid = !halted;
	assign out.pkt = fetch_pkt;
	assign fire = out.valid && out.ready;

	// squash wins over both advance and halt
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			halted <= 1'b0;
		end else if (squash) begin
			pc <= squash_pc;
			halted <= 1'b0;
		end else begin
			if (fire)
				pc <= pc + xlen'(4);
			// wfi already in decode, stop offering words
			if (halt_accepted)
				halted <= 1'b1;
		end
	end

	// redirect targets come from the rob, keep them aligned
	a_pc_aligned: assert property (
		@(posedge clock) disable iff (reset)
		pc[1:0] == 2'b00
	) else $error("fetch pc not word aligned");

endmodule

/* hdl/inst_decoder.sv */
////////////////////////////////////////////////////////////
// instruction decoder
// combinational rv32i plus m-extension multiplies, maps
// one word onto operand selects, alu function and flags
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module inst_decoder import frontend_pkg::*; (
	input inst_t inst,
	output opa_sel_t opa_sel,
	output opb_sel_t opb_sel,
	output alu_func_t alu_func,
	output logic dest_used,
	output logic rd_mem,
	output logic wr_mem,
	output logic cond_branch,
	output logic uncond_branch,
	output logic csr_op,
	output logic halt,
	output logic illegal
);

	always_comb begin
		// defaults behave as a no-op
		opa_sel = opa_rs1;
		opb_sel = opb_rs2;
		alu_func = alu_add;
		rd_mem = 1'b0;
		wr_mem = 1'b0;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		csr_op = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;
		// patterns are funct7 | rs2 rs1 | funct3 | rd | opcode
		casez (inst.raw)
			{25'b?, opc_lui}: begin
				opa_sel = opa_zero;
				opb_sel = opb_u_imm;
			end
			{25'b?, opc_auipc}: begin
				opa_sel = opa_pc;
				opb_sel = opb_u_imm;
			end
			{25'b?, opc_jal}: begin
				opa_sel = opa_pc;
				opb_sel = opb_j_imm;
				uncond_branch = 1'b1;
			end
			{17'b?, 3'b000, 5'b?, opc_jalr}: begin
				opb_sel = opb_i_imm;
				uncond_branch = 1'b1;
			end
			// beq bne blt bge bltu bgeu
			{17'b?, 3'b000, 5'b?, opc_branch}, {17'b?, 3'b001, 5'b?, opc_branch},
			{17'b?, 3'b100, 5'b?, opc_branch}, {17'b?, 3'b101, 5'b?, opc_branch},
			{17'b?, 3'b110, 5'b?, opc_branch}, {17'b?, 3'b111, 5'b?, opc_branch}: begin
				opa_sel = opa_pc;
				opb_sel = opb_b_imm;
				cond_branch = 1'b1;
			end
			// lb lh lw lbu lhu
			{17'b?, 3'b000, 5'b?, opc_load}, {17'b?, 3'b001, 5'b?, opc_load},
			{17'b?, 3'b010, 5'b?, opc_load}, {17'b?, 3'b100, 5'b?, opc_load},
			{17'b?, 3'b101, 5'b?, opc_load}: begin
				opb_sel = opb_i_imm;
				rd_mem = 1'b1;
			end
			// sb sh sw
			{17'b?, 3'b000, 5'b?, opc_store}, {17'b?, 3'b001, 5'b?, opc_store},
			{17'b?, 3'b010, 5'b?, opc_store}: begin
				opb_sel = opb_s_imm;
				wr_mem = 1'b1;
			end
			// immediate alu group, function picked below
			{25'b?, opc_op_imm}: begin
				opb_sel = opb_i_imm;
				casez (inst.raw)
					{17'b?, 3'b000, 12'b?}: alu_func = alu_add;
					{17'b?, 3'b010, 12'b?}: alu_func = alu_slt;
					{17'b?, 3'b011, 12'b?}: alu_func = alu_sltu;
					{17'b?, 3'b111, 12'b?}: alu_func = alu_and;
					{17'b?, 3'b110, 12'b?}: alu_func = alu_or;
					{17'b?, 3'b100, 12'b?}: alu_func = alu_xor;
					{7'b0000000, 10'b?, 3'b001, 12'b?}: alu_func = alu_sll;
					{7'b0000000, 10'b?, 3'b101, 12'b?}: alu_func = alu_srl;
					{7'b0100000, 10'b?, 3'b101, 12'b?}: alu_func = alu_sra;
					default: begin
						// bad shift encoding, back to no-op selects
						opb_sel = opb_rs2;
						illegal = 1'b1;
					end
				endcase
			end
			// register alu group and multiplies
			{25'b?, opc_op}: begin
				casez (inst.raw)
					{7'b0000000, 10'b?, 3'b000, 12'b?}: alu_func = alu_add;
					{7'b0100000, 10'b?, 3'b000, 12'b?}: alu_func = alu_sub;
					{7'b0000000, 10'b?, 3'b010, 12'b?}: alu_func = alu_slt;
					{7'b0000000, 10'b?, 3'b011, 12'b?}: alu_func = alu_sltu;
					{7'b0000000, 10'b?, 3'b111, 12'b?}: alu_func = alu_and;
					{7'b0000000, 10'b?, 3'b110, 12'b?}: alu_func = alu_or;
					{7'b0000000, 10'b?, 3'b100, 12'b?}: alu_func = alu_xor;
					{7'b0000000, 10'b?, 3'b001, 12'b?}: alu_func = alu_sll;
					{7'b0000000, 10'b?, 3'b101, 12'b?}: alu_func = alu_srl;
					{7'b0100000, 10'b?, 3'b101, 12'b?}: alu_func = alu_sra;
					{7'b0000001, 10'b?, 3'b000, 12'b?}: alu_func = alu_mul;
					{7'b0000001, 10'b?, 3'b001, 12'b?}: alu_func = alu_mulh;
					{7'b0000001, 10'b?, 3'b010, 12'b?}: alu_func = alu_mulhsu;
					{7'b0000001, 10'b?, 3'b011, 12'b?}: alu_func = alu_mulhu;
					default: illegal = 1'b1;
				endcase
			end
			// csrrw csrrs csrrc
			{17'b?, 3'b001, 5'b?, opc_system}, {17'b?, 3'b010, 5'b?, opc_system},
			{17'b?, 3'b011, 5'b?, opc_system}: csr_op = 1'b1;
			// wfi, fixed encoding
			{12'h105, 5'd0, 3'b000, 5'd0, opc_system}: halt = 1'b1;
			default: illegal = 1'b1;
		endcase
		// everything else writes rd
		dest_used = !(illegal || cond_branch || wr_mem || csr_op || halt);
	end

endmodule

/* hdl/decode_stage.sv */
////////////////////////////////////////////////////////////
// decode stage
// one pipeline register behind the decoder, adds register
// indices with use flags and reports halt acceptance
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module decode_stage import frontend_pkg::*; (
	input logic clock,
	input logic reset,
	input logic squash,
	stage_if.consumer in,
	stage_if.producer out,
	output logic halt_accepted
);

	inst_t inst;
	logic [6:0] opcode;
	opa_sel_t opa_sel;
	opb_sel_t opb_sel;
	alu_func_t alu_func;
	logic dest_used;
	logic rd_mem;
	logic wr_mem;
	logic cond_branch;
	logic uncond_branch;
	logic csr_op;
	logic halt;
	logic illegal;
	logic rs1_used;
	logic rs2_used;
	logic take;
	logic valid_q;
	decoded_pkt_t pkt_d;
	decoded_pkt_t pkt_q;

	assign inst = in.pkt.inst;
	assign opcode = inst.u.opcode;

	inst_decoder decoder_i (
		.inst(inst),
		.opa_sel(opa_sel),
		.opb_sel(opb_sel),
		.alu_func(alu_func),
		.dest_used(dest_used),
		.rd_mem(rd_mem),
		.wr_mem(wr_mem),
		.cond_branch(cond_branch),
		.uncond_branch(uncond_branch),
		.csr_op(csr_op),
		.halt(halt),
		.illegal(illegal)
	);

	// source use by opcode class, nothing for illegal words
	assign rs1_used = !illegal && !(opcode inside {opc_lui, opc_auipc, opc_jal, opc_system});
	assign rs2_used = !illegal && (opcode inside {opc_op, opc_branch, opc_store});

	always_comb begin
		pkt_d.pc = in.pkt.pc;
		pkt_d.inst = inst;
		pkt_d.opa_sel = opa_sel;
		pkt_d.opb_sel = opb_sel;
		pkt_d.alu_func = alu_func;
		pkt_d.dest_idx = dest_used ? inst.r.rd : zero_reg;
		pkt_d.rs1_idx = rs1_used ? inst.r.rs1 : zero_reg;
		pkt_d.rs1_used = rs1_used;
		pkt_d.rs2_idx = rs2_used ? inst.r.rs2 : zero_reg;
		pkt_d.rs2_used = rs2_used;
		pkt_d.rd_mem = rd_mem;
		pkt_d.wr_mem = wr_mem;
		pkt_d.cond_branch = cond_branch;
		pkt_d.uncond_branch = uncond_branch;
		pkt_d.csr_op = csr_op;
		pkt_d.halt = halt;
		pkt_d.illegal = illegal;
	end

	// room when empty or draining this cycle
	assign in.ready = !valid_q || out.ready;
	assign take = in.valid && in.ready;
	// fetch parks on this, squash still has priority there
	assign halt_accepted = take && halt;

	assign out.valid = valid_q;
	assign out.pkt = pkt_q;

	always_ff @(posedge clock) begin
		if (reset || squash)
			valid_q <= 1'b0;
		else if (take)
			valid_q <= 1'b1;
		else if (out.ready)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (take)
			pkt_q <= pkt_d;
	end

	// fetch must keep offering the same word while this register is full
	a_hold_stable: assert property (
		@(posedge clock) disable iff (reset)
		(in.valid && !in.ready && !squash) |=> (in.valid && $stable(in.pkt))
	) else $error("fetch packet changed while decode stalled");

endmodule

/* hdl/dispatch_queue.sv */
////////////////////////////////////////////////////////////
// dispatch queue
// circular FIFO of decoded packets toward the back end,
// emptied in one cycle on squash
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dispatch_queue import frontend_pkg::*; #(
	parameter int queue_depth = 4
) (
	input logic clock,
	input logic reset,
	input logic squash,
	stage_if.consumer in,
	output logic dispatch_valid,
	input logic dispatch_ready,
	output decoded_pkt_t head
);

	localparam int ptr_w = $clog2(queue_depth);
	localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(queue_depth);

	decoded_pkt_t mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic push;
	logic pop;

	assign in.ready = count != full_count;
	assign dispatch_valid = count != '0;
	assign head = mem[rd_ptr];

	assign push = in.valid && in.ready;
	assign pop = dispatch_valid && dispatch_ready;

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset || squash) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop keeps count
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= in.pkt;
	end

	// occupancy stays within depth and in step with the pointers
	a_no_overflow: assert property (
		@(posedge clock) disable iff (reset)
		(count <= full_count) && (ptr_w'(wr_ptr - rd_ptr) == count[ptr_w-1:0])
	) else $error("dispatch queue overflow or underflow");

endmodule

/* hdl/rv_front_end.sv */
////////////////////////////////////////////////////////////
// rv32im front end top
// fetch, decode and dispatch queue in a chain, squash from
// the rob fans out to every stage, packet fields leave on
// plain ports
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rv_front_end import frontend_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = '0,
	parameter int queue_depth = 4
) (
	input logic clock,
	input logic reset,
	output logic [xlen-1:0] imem_addr,
	input logic [63:0] imem_data,
	input logic squash,
	input logic [xlen-1:0] squash_pc,
	output logic dispatch_valid,
	input logic dispatch_ready,
	output logic [xlen-1:0] dispatch_pc,
	output logic [31:0] dispatch_inst,
	output opa_sel_t dispatch_opa_sel,
	output opb_sel_t dispatch_opb_sel,
	output alu_func_t dispatch_alu_func,
	output logic [4:0] dispatch_dest_idx,
	output logic [4:0] dispatch_rs1_idx,
	output logic dispatch_rs1_used,
	output logic [4:0] dispatch_rs2_idx,
	output logic dispatch_rs2_used,
	output logic dispatch_rd_mem,
	output logic dispatch_wr_mem,
	output logic dispatch_cond_branch,
	output logic dispatch_uncond_branch,
	output logic dispatch_csr_op,
	output logic dispatch_halt,
	output logic dispatch_illegal
);

	logic halt_accepted;
	decoded_pkt_t head;

	stage_if #(.pkt_t(fetch_pkt_t)) fetch_to_decode ();
	stage_if #(.pkt_t(decoded_pkt_t)) decode_to_queue ();

	fetch_stage #(.reset_pc(reset_pc)) fetch_i (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.squash_pc(squash_pc),
		.halt_accepted(halt_accepted),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.out(fetch_to_decode.producer)
	);

	decode_stage decode_i (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.in(fetch_to_decode.consumer),
		.out(decode_to_queue.producer),
		.halt_accepted(halt_accepted)
	);

	dispatch_queue #(.queue_depth(queue_depth)) queue_i (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.in(decode_to_queue.consumer),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.head(head)
	);

	// head entry split onto the back end ports
	assign dispatch_pc = head.pc;
	assign dispatch_inst = head.inst.raw;
	assign dispatch_opa_sel = head.opa_sel;
	assign dispatch_opb_sel = head.opb_sel;
	assign dispatch_alu_func = head.alu_func;
	assign dispatch_dest_idx = head.dest_idx;
	assign dispatch_rs1_idx = head.rs1_idx;
	assign dispatch_rs1_used = head.rs1_used;
	assign dispatch_rs2_idx = head.rs2_idx;
	assign dispatch_rs2_used = head.rs2_used;
	assign dispatch_rd_mem = head.rd_mem;
	assign dispatch_wr_mem = head.wr_mem;
	assign dispatch_cond_branch = head.cond_branch;
	assign dispatch_uncond_branch = head.uncond_branch;
	assign dispatch_csr_op = head.csr_op;
	assign dispatch_halt = head.halt;
	assign dispatch_illegal = head.illegal;

endmodule

/* dv/rv_front_end_tb.sv */
////////////////////////////////////////////////////////////
// front end testbench
// replays a trace of memory image, squash events and
// expected dispatch packets against the front end, with
// random back-pressure on the dispatch port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rv_front_end_tb;

	localparam int max_exp = 64;
	localparam int n_fields = 17;
	// addi x0, x0, 0 in both halves
	localparam logic [63:0] nop_pair = 64'h00000013_00000013;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] imem_addr;
	logic [63:0] imem_data;
	logic squash;
	logic [31:0] squash_pc;
	logic dispatch_valid;
	logic dispatch_ready;
	logic [31:0] dispatch_pc;
	logic [31:0] dispatch_inst;
	logic [1:0] dispatch_opa_sel;
	logic [2:0] dispatch_opb_sel;
	logic [3:0] dispatch_alu_func;
	logic [4:0] dispatch_dest_idx;
	logic [4:0] dispatch_rs1_idx;
	logic dispatch_rs1_used;
	logic [4:0] dispatch_rs2_idx;
	logic dispatch_rs2_used;
	logic dispatch_rd_mem;
	logic dispatch_wr_mem;
	logic dispatch_cond_branch;
	logic dispatch_uncond_branch;
	logic dispatch_csr_op;
	logic dispatch_halt;
	logic dispatch_illegal;

	// trace contents
	logic [63:0] imem [logic [31:0]];
	int image_version = 0;
	logic [31:0] exp_pkt [max_exp][n_fields];
	int n_exp = 0;
	int sq_count [$];
	logic [31:0] sq_target [$];
	string field_name [n_fields] = '{"pc", "inst", "opa_sel", "opb_sel", "alu_func",
		"dest_idx", "rs1_idx", "rs1_used", "rs2_idx", "rs2_used", "rd_mem", "wr_mem",
		"cond_branch", "uncond_branch", "csr_op", "halt", "illegal"};

	// run state
	logic [31:0] rng_state = 32'h1e42dcc0;
	int n_disp = 0;
	int sq_idx = 0;
	int cycles = 0;
	int limit = 0;
	int quiet = 0;
	int errors = 0;
	int seg_errors = 0;
	int seg_packets = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_num = 0;
	logic [31:0] seg_start_pc = 32'h0;
	logic timed_out = 1'b0;
	logic last_halt = 1'b0;

	rv_front_end #(.reset_pc(32'h0), .queue_depth(4)) dut_i (
		.clock(clock),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.squash(squash),
		.squash_pc(squash_pc),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.dispatch_pc(dispatch_pc),
		.dispatch_inst(dispatch_inst),
		.dispatch_opa_sel(dispatch_opa_sel),
		.dispatch_opb_sel(dispatch_opb_sel),
		.dispatch_alu_func(dispatch_alu_func),
		.dispatch_dest_idx(dispatch_dest_idx),
		.dispatch_rs1_idx(dispatch_rs1_idx),
		.dispatch_rs1_used(dispatch_rs1_used),
		.dispatch_rs2_idx(dispatch_rs2_idx),
		.dispatch_rs2_used(dispatch_rs2_used),
		.dispatch_rd_mem(dispatch_rd_mem),
		.dispatch_wr_mem(dispatch_wr_mem),
		.dispatch_cond_branch(dispatch_cond_branch),
		.dispatch_uncond_branch(dispatch_uncond_branch),
		.dispatch_csr_op(dispatch_csr_op),
		.dispatch_halt(dispatch_halt),
		.dispatch_illegal(dispatch_illegal)
	);

	always #5 clock = ~clock;

	// same-cycle doubleword read, no-op pair outside the image
	always @(imem_addr or image_version) begin
		if (imem.exists(imem_addr))
			imem_data = imem[imem_addr];
		else
			imem_data = nop_pair;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////////////////////////
	// trace reader, first token of a line picks its kind
	////////////////////////////////////////////////////////////

	task automatic read_trace();
		int fd;
		int code;
		int count;
		logic [8*8-1:0] kind;
		logic [8*160-1:0] rest;
		logic [31:0] addr;
		logic [63:0] word;
		logic [31:0] f [n_fields];
		fd = $fopen("dv/front_end_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file dv/front_end_trace.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1)
				break;
			if (kind == "#") begin
				code = $fgets(rest, fd);
			end else if (kind == "m") begin
				code = $fscanf(fd, "%h %h", addr, word);
				imem[addr] = word;
			end else if (kind == "s") begin
				code = $fscanf(fd, "%d %h", count, addr);
				sq_count.push_back(count);
				sq_target.push_back(addr);
			end else if (kind == "e" && n_exp < max_exp) begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (code != n_fields) begin
					$display("expected-packet line %0d of the trace is malformed", n_exp);
					errors++;
				end
				for (int k = 0; k < n_fields; k++)
					exp_pkt[n_exp][k] = f[k];
				n_exp++;
			end else begin
				$display("trace line of unknown kind %0s skipped", kind);
				errors++;
				code = $fgets(rest, fd);
			end
		end
		$fclose(fd);
	endtask

	// field by field against the next expected entry
	task automatic check_packet();
		logic [31:0] act [n_fields];
		act[0] = dispatch_pc;
		act[1] = dispatch_inst;
		act[2] = 32'(dispatch_opa_sel);
		act[3] = 32'(dispatch_opb_sel);
		act[4] = 32'(dispatch_alu_func);
		act[5] = 32'(dispatch_dest_idx);
		act[6] = 32'(dispatch_rs1_idx);
		act[7] = 32'(dispatch_rs1_used);
		act[8] = 32'(dispatch_rs2_idx);
		act[9] = 32'(dispatch_rs2_used);
		act[10] = 32'(dispatch_rd_mem);
		act[11] = 32'(dispatch_wr_mem);
		act[12] = 32'(dispatch_cond_branch);
		act[13] = 32'(dispatch_uncond_branch);
		act[14] = 32'(dispatch_csr_op);
		act[15] = 32'(dispatch_halt);
		act[16] = 32'(dispatch_illegal);
		for (int k = 0; k < n_fields; k++) begin
			if (act[k] !== exp_pkt[n_disp][k]) begin
				$display("error t=%0t dispatch_%0s: expected %h, got %h",
					$time, field_name[k], exp_pkt[n_disp][k], act[k]);
				errors++;
				seg_errors++;
			end
		end
	endtask

	// one test per trace segment, closed by a squash or the end
	task automatic report_test();
		test_num++;
		if (seg_errors == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %0d from pc %h: %0d packets, %0d errors",
			test_num, seg_start_pc, seg_packets, seg_errors);
		seg_errors = 0;
		seg_packets = 0;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		squash = 1'b0;
		squash_pc = 32'h0;
		dispatch_ready = 1'b0;
		read_trace();
		image_version++;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		#1;
		if (dispatch_valid) begin
			$display("dispatch_valid is high right after reset");
			errors++;
			seg_errors++;
		end
		limit = 20 * n_exp + 100;
		while (n_disp < n_exp && !timed_out) begin
			@(negedge clock);
			cycles++;
			squash = 1'b0;
			if (cycles > limit) begin
				$display("timeout after %0d cycles with %0d of %0d packets dispatched",
					cycles, n_disp, n_exp);
				timed_out = 1'b1;
				errors++;
				seg_errors++;
			end else begin
				// after a halt, stay quiet for 50 cycles before the redirect
				if (sq_idx < sq_count.size() && n_disp == sq_count[sq_idx] &&
						!(last_halt && quiet < 50)) begin
					squash = 1'b1;
					squash_pc = sq_target[sq_idx];
					// hold dispatch so nothing from the old path leaves
					dispatch_ready = 1'b0;
					sq_idx++;
					quiet = 0;
					last_halt = 1'b0;
					report_test();
					seg_start_pc = squash_pc;
				end else begin
					if (last_halt)
						quiet++;
					// about 70 percent ready
					rng_state = xorshift32(rng_state);
					dispatch_ready = (rng_state % 100) < 70;
				end
				#1;
				if (last_halt && dispatch_valid) begin
					$display("packet at pc %h offered while the front end is halted",
						dispatch_pc);
					errors++;
					seg_errors++;
				end
				// transfer happens at the coming rising edge
				if (dispatch_valid && dispatch_ready) begin
					check_packet();
					last_halt = exp_pkt[n_disp][15][0];
					n_disp++;
					seg_packets++;
				end
			end
		end
		report_test();
		$display("tests passed %0d, failed %0d, packets %0d of %0d",
			tests_passed, tests_failed, n_disp, n_exp);
		if (errors == 0 && n_exp > 0 && n_disp == n_exp)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* dv/front_end_trace.txt */
# m addr word64 | s dispatch_count target
# e pc inst opa_sel opb_sel alu_func dest_idx rs1_idx rs1_used rs2_idx rs2_used
#   rd_mem wr_mem cond_branch uncond_branch csr_op halt illegal (all hex)
m 00000000 00001117123450b7
m 00000008 00808267010001ef
m 00000010 0041228300208463
m 00000018 fff484130063a623
m 00000020 403cdc1300100f93
m 00000028 4010101301cdcd33
m 00000040 40f706b300c58533
m 00000048 035a39b303288833
m 00000050 ffffffff300b9b73
m 00000058 0000001310500073
# lui auipc jal jalr beq lw sw addi from the reset pc
e 00000000 123450b7 2 4 0 01 00 0 00 0 0 0 0 0 0 0 0
e 00000004 00001117 1 4 0 02 00 0 00 0 0 0 0 0 0 0 0
e 00000008 010001ef 1 5 0 03 00 0 00 0 0 0 0 1 0 0 0
e 0000000c 00808267 0 1 0 04 01 1 00 0 0 0 0 1 0 0 0
e 00000010 00208463 1 3 0 00 01 1 02 1 0 0 1 0 0 0 0
e 00000014 00412283 0 1 0 05 02 1 00 0 1 0 0 0 0 0 0
e 00000018 0063a623 0 2 0 00 07 1 06 1 0 1 0 0 0 0 0
e 0000001c fff48413 0 1 0 08 09 1 00 0 0 0 0 0 0 0 0
s 8 00000040
# add sub mul mulhu csrrw illegal wfi
e 00000040 00c58533 0 0 0 0a 0b 1 0c 1 0 0 0 0 0 0 0
e 00000044 40f706b3 0 0 1 0d 0e 1 0f 1 0 0 0 0 0 0 0
e 00000048 03288833 0 0 a 10 11 1 12 1 0 0 0 0 0 0 0
e 0000004c 035a39b3 0 0 d 13 14 1 15 1 0 0 0 0 0 0 0
e 00000050 300b9b73 0 0 0 00 00 0 00 0 0 0 0 0 1 0 0
e 00000054 ffffffff 0 0 0 00 00 0 00 0 0 0 0 0 0 0 1
e 00000058 10500073 0 0 0 00 00 0 00 0 0 0 0 0 0 1 0
s 15 00000024
# restart in an upper half, srai xor and a bad shift
e 00000024 403cdc13 0 1 9 18 19 1 00 0 0 0 0 0 0 0 0
e 00000028 01cdcd33 0 0 6 1a 1b 1 1c 1 0 0 0 0 0 0 0
e 0000002c 40101013 0 0 0 00 00 0 00 0 0 0 0 0 0 0 1

/* rv_front_end.f */
hdl/frontend_pkg.sv
hdl/stage_if.sv
hdl/fetch_stage.sv
hdl/inst_decoder.sv
hdl/decode_stage.sv
hdl/dispatch_queue.sv
hdl/rv_front_end.sv
dv/rv_front_end_tb.sv

/* Makefile */
# Verilator build and run of the front end testbench

VERILATOR ?= verilator
TOP ?= rv_front_end_tb
FLAGS ?= --binary --timing -Wno-fatal
FILELIST ?= rv_front_end.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(BUILD_DIR)
